/* bench/tb_text.sv */
/*
 * Testbench for the register display
 * Random APB traffic checked against a model of both banks and the pixel stream
 */
`include "text_defs.svh"

module tb_text;
	timeunit 1ns;
	timeprecision 100ps;

	import text_pkg::*;

	localparam int TITLE_WRITES = `TEXT_TITLE_LEN * `TEXT_GLYPH * `TEXT_GLYPH;
	localparam int PANEL_WRITES = `TEXT_REG_ROWS * `TEXT_REG_COLS * `TEXT_GLYPH * `TEXT_GLYPH;
	localparam int APB_SLACK = 1544;
	localparam int TIMEOUT_CYCLES = TITLE_WRITES + 3 * PANEL_WRITES + APB_SLACK;

	localparam int T_RESET = 0;
	localparam int T_APB_RW = 1;
	localparam int T_APB_RANGE = 2;
	localparam int T_TITLE = 3;
	localparam int T_PANEL1 = 4;
	localparam int T_PANEL2 = 5;
	localparam int T_DONE = 6;
	localparam int N_TESTS = 7;

	logic       clock = 1'b0;
	logic       resetn = 1'b0;
	logic       psel;
	logic       penable;
	logic       pwrite;
	logic [7:0] paddr;
	disp_word_u pwdata;
	disp_word_u prdata;
	logic       pready;
	logic       pslverr;
	coord_x_t   pix_x;
	coord_y_t   pix_y;
	color_t     pix_color;
	logic       pix_write;
	logic       panel_done;

	disp_word_u model_live [`TEXT_REG_ROWS];
	disp_word_u model_shown [`TEXT_REG_ROWS];
	int         writes = 0;    // Pixel writes seen since alignment
	bit         aligned = 1'b0;
	bit         gap_seen = 1'b0;
	int         done_count = 0;
	int         errs [N_TESTS];
	int         n_pass = 0;
	int         n_fail = 0;
	int         cycles = 0;
	int         seed = 32'h3d99_7bf3;

	text_top dut_i (
		.clock     (clock),
		.resetn    (resetn),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.pix_x     (pix_x),
		.pix_y     (pix_y),
		.pix_color (pix_color),
		.pix_write (pix_write),
		.panel_done(panel_done)
	);

	always #5 clock = ~clock;

	always @(posedge clock) cycles <= cycles + 1;

	always @(negedge clock) begin
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d pixel writes seen", cycles, writes);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic string test_name(input int id);
		case (id)
			T_RESET: return "reset";
			T_APB_RW: return "apb_readback";
			T_APB_RANGE: return "apb_range";
			T_TITLE: return "title";
			T_PANEL1: return "panel1";
			T_PANEL2: return "panel2";
			default: return "panel_done";
		endcase
	endfunction

	task automatic check_pixel(input int test, input coord_x_t ex, input coord_y_t ey,
			input color_t ec, input coord_x_t ax, input coord_y_t ay, input color_t ac);
		if (ex !== ax || ey !== ay || ec !== ac) begin
			$display("FAIL %s: write %0d expected x=%0d y=%0d color=%h, actual x=%0d y=%0d color=%h",
				test_name(test), writes, ex, ey, ec, ax, ay, ac);
			errs[test]++;
		end
	endtask

	task automatic check_word(input int test, input string what, input disp_word_u exp,
			input disp_word_u act);
		if (exp !== act) begin
			$display("FAIL %s: %s expected %h, actual %h", test_name(test), what, exp, act);
			errs[test]++;
		end
	endtask

	task automatic check_flag(input int test, input string what, input logic exp,
			input logic act);
		if (exp !== act) begin
			$display("FAIL %s: %s expected %b, actual %b", test_name(test), what, exp, act);
			errs[test]++;
		end
	endtask

	// Expected pixel for write number idx, counted from the first title write
	task automatic model_pixel(input int idx, output coord_x_t ex, output coord_y_t ey,
			output color_t ec);
		int          n;
		int          px;
		int          py;
		int          col;
		int          row;
		bit          title;
		bit          lit;
		glyph_code_t code;
		disp_word_u  w;
		title = (idx < TITLE_WRITES);
		n = title ? idx : (idx - TITLE_WRITES) % PANEL_WRITES;
		px = n % 8;
		py = (n / 8) % 8;
		col = title ? n / 64 : (n / 64) % `TEXT_REG_COLS;
		row = title ? 0 : n / (64 * `TEXT_REG_COLS);
		w = model_shown[row];
		if (title)
			code = TITLE_TEXT[col];
		else if (col == 0)
			code = CODE_R;
		else if (col == 1)
			code = glyph_code_t'(row);
		else if (col == 2)
			code = CODE_COLON;
		else if (col == 3)
			code = CODE_SPACE;
		else
			code = glyph_code_t'((w.word >> (4 * (11 - col))) & 32'hF);    // Top digit first
		lit = FONT[code][8 * py + 7 - px];
		ex = coord_x_t'(`TEXT_X_BASE + col * `TEXT_CHAR_PITCH + px);
		if (title)
			ey = coord_y_t'(`TEXT_TITLE_Y + py);
		else
			ey = coord_y_t'(`TEXT_REG_Y + row * `TEXT_ROW_PITCH + py);
		ec = lit ? 9'h1FF : 9'h000;
	endtask

	task automatic watch_outputs();
		coord_x_t ex;
		coord_y_t ey;
		color_t   ec;
		int       test;
		bit       last;
		if (!pix_write) begin
			check_flag(T_DONE, "panel_done without a write", 1'b0, panel_done);
			if (aligned) begin
				if (!gap_seen)
					$display("pix_write dropped low after %0d writes", writes);
				gap_seen = 1'b1;
				errs[T_DONE]++;
			end
		end else begin
			aligned = 1'b1;
			if (writes < TITLE_WRITES)
				test = T_TITLE;
			else if (writes < TITLE_WRITES + PANEL_WRITES)
				test = T_PANEL1;
			else
				test = T_PANEL2;
			model_pixel(writes, ex, ey, ec);
			check_pixel(test, ex, ey, ec, pix_x, pix_y, pix_color);
			last = (writes >= TITLE_WRITES) &&
				((writes - TITLE_WRITES) % PANEL_WRITES == PANEL_WRITES - 1);
			check_flag(T_DONE, "panel_done", last, panel_done);
			if (panel_done)
				done_count++;
			if (writes == TITLE_WRITES - 1 || last)
				model_shown = model_live;    // Snapshot on the edge of the line's last write
			writes++;
		end
	endtask

	task automatic step();
		@(negedge clock);
		watch_outputs();
	endtask

	// Setup, access, then sample while the access is still held
	task automatic apb_access(input int test, input logic write, input logic [7:0] addr,
			input disp_word_u data, output disp_word_u rdata, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		step();
		penable = 1'b1;
		step();
		rdata = prdata;
		err = pslverr;
		check_flag(test, "pready", 1'b1, pready);
		if (write && addr <= `TEXT_APB_LAST)
			model_live[addr[4:2]] = data;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic report_test(input int id);
		if (errs[id] == 0) begin
			n_pass++;
			$display("test %s: ok", test_name(id));
		end else begin
			n_fail++;
			$display("test %s: %0d errors", test_name(id), errs[id]);
		end
	endtask

	initial begin
		disp_word_u data;
		disp_word_u rd;
		logic       err;
		logic [7:0] addr;
		int         k;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		for (k = 0; k < N_TESTS; k++)
			errs[k] = 0;
		for (k = 0; k < `TEXT_REG_ROWS; k++) begin
			model_live[k] = '0;
			model_shown[k] = '0;
		end

		for (k = 0; k < 2; k++) begin
			step();
			check_flag(T_RESET, "pix_write in reset", 1'b0, pix_write);
			check_flag(T_RESET, "panel_done in reset", 1'b0, panel_done);
		end
		resetn = 1'b1;
		step();
		check_flag(T_RESET, "pix_write after reset", 1'b0, pix_write);
		check_flag(T_RESET, "panel_done after reset", 1'b0, panel_done);
		check_flag(T_RESET, "pslverr after reset", 1'b0, pslverr);
		report_test(T_RESET);

		// All eight words first, then a few more at random
		for (k = 0; k < 16; k++) begin
			data.word = $random(seed);
			addr = (k < 8) ? 8'(k * 4) : 8'(($random(seed) & 7) * 4);
			apb_access(T_APB_RW, 1'b1, addr, data, rd, err);
			check_flag(T_APB_RW, "pslverr on write", 1'b0, err);
		end
		for (k = 0; k < `TEXT_REG_ROWS; k++) begin
			apb_access(T_APB_RW, 1'b0, 8'(k * 4), '0, rd, err);
			check_word(T_APB_RW, $sformatf("read 0x%h", 8'(k * 4)), model_live[k], rd);
			check_flag(T_APB_RW, "pslverr on read", 1'b0, err);
		end
		report_test(T_APB_RW);

		for (k = 0; k < 12; k++) begin
			data.word = $random(seed);
			addr = 8'h20 + 8'($unsigned($random(seed)) % 224);
			if (k % 2 == 0) begin
				apb_access(T_APB_RANGE, 1'b1, addr, data, rd, err);
				check_flag(T_APB_RANGE, $sformatf("pslverr on write 0x%h", addr), 1'b1, err);
			end else begin
				apb_access(T_APB_RANGE, 1'b0, addr, '0, rd, err);
				check_flag(T_APB_RANGE, $sformatf("pslverr on read 0x%h", addr), 1'b1, err);
				check_word(T_APB_RANGE, $sformatf("read 0x%h", addr), '0, rd);
			end
		end
		for (k = 0; k < `TEXT_REG_ROWS; k++) begin
			apb_access(T_APB_RANGE, 1'b0, 8'(k * 4), '0, rd, err);
			check_word(T_APB_RANGE, $sformatf("word %0d kept", k), model_live[k], rd);
		end
		report_test(T_APB_RANGE);

		while (writes < TITLE_WRITES)
			step();
		report_test(T_TITLE);

		// New values while panel 1 is drawn, due in panel 2
		while (writes < TITLE_WRITES + 200)
			step();
		for (k = 0; k < `TEXT_REG_ROWS; k++) begin
			data.word = $random(seed);
			apb_access(T_PANEL2, 1'b1, 8'(k * 4), data, rd, err);
		end
		while (writes < TITLE_WRITES + PANEL_WRITES)
			step();
		report_test(T_PANEL1);

		// One write past panel 2 to see the return to the origin
		while (writes < TITLE_WRITES + 2 * PANEL_WRITES + 1)
			step();
		report_test(T_PANEL2);

		if (done_count != 2) begin
			$display("panel_done pulsed %0d times over two panels", done_count);
			errs[T_DONE]++;
		end
		report_test(T_DONE);

		$display("summary: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* hw/apb_regs.sv */
/*
 * APB register bank for the display
 * Eight live words plus the bank that the current panel is drawn from
 */
`include "text_defs.svh"

module apb_regs (
	input  logic                 clock,
	input  logic                 resetn,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [7:0]           paddr,
	input  text_pkg::disp_word_u pwdata,
	output text_pkg::disp_word_u prdata,
	output logic                 pready,
	output logic                 pslverr,
	input  logic                 panel_start,
	output text_pkg::disp_word_u shown [`TEXT_REG_ROWS]
);
	import text_pkg::*;

	disp_word_u live [`TEXT_REG_ROWS];
	logic [2:0] idx;
	logic       in_range;
	logic       access;

	assign idx = paddr[4:2];    // Byte lanes ignored
	assign in_range = (paddr <= `TEXT_APB_LAST);
	assign access = psel && penable;

	assign pready = 1'b1;    // Zero wait states
	assign pslverr = access && !in_range;

	// Out of range reads return zero
	assign prdata = (psel && !pwrite && in_range) ? live[idx] : '0;

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			for (int k = 0; k < `TEXT_REG_ROWS; k++)
				live[k] <= '0;
		end else if (access && pwrite && in_range) begin
			live[idx] <= pwdata;
		end
	end

	// Snapshot taken on the edge that starts a panel
	always_ff @(posedge clock) begin
		if (panel_start)
			shown <= live;
	end

	// An access phase always follows a setup phase or continues one
	assert property (@(posedge clock) disable iff (!resetn)
		penable |-> psel && ($past(psel) || $past(penable)))
		else $error("penable without a selected setup phase");

endmodule

/* hw/char_select.sv */
/*
 * Character code at the current scan position
 * Title text, or the R<n>: layout followed by the shown word in hex
 */
`include "text_defs.svh"

module char_select (
	input  text_pkg::phase_t      phase,
	input  logic [3:0]            col,
	input  logic [2:0]            row,
	input  text_pkg::disp_word_u  shown [`TEXT_REG_ROWS],
	output text_pkg::glyph_code_t code
);
	import text_pkg::*;

	disp_word_u cur_word;
	logic [2:0] nib_sel;

	assign cur_word = shown[row];

	// Column 4 shows the top digit
	assign nib_sel = 3'(`TEXT_REG_COLS - 1 - col);

	always_comb begin
		code = CODE_SPACE;
		case (phase)
			TITLE: code = TITLE_TEXT[col];
			PANEL: begin
				case (col)
					4'd0: code = CODE_R;
					4'd1: code = glyph_code_t'(row);    // Digit codes equal their value
					4'd2: code = CODE_COLON;
					4'd3: code = CODE_SPACE;
					default: code = {2'b00, cur_word.nib[nib_sel]};
				endcase
			end
			default: code = CODE_SPACE;
		endcase
	end

endmodule

/* hw/draw_sequencer.sv */
/*
 * Drawing sequencer
 * Title once after reset, then register panels back to back
 */
module draw_sequencer (
	input  logic             clock,
	input  logic             resetn,
	input  logic             line_end,
	output text_pkg::phase_t phase,
	output logic             panel_start,
	output logic             panel_done
);
	import text_pkg::*;

	phase_t phase_next;

	always_comb begin
		phase_next = phase;
		case (phase)
			RESET_WAIT: phase_next = TITLE;
			TITLE: begin
				if (line_end)
					phase_next = PANEL;
			end
			PANEL: phase_next = PANEL;    // Panels repeat forever
			default: phase_next = RESET_WAIT;
		endcase
	end

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn)
			phase <= RESET_WAIT;
		else
			phase <= phase_next;
	end

	// High on the edge that enters the next panel
	assign panel_start = line_end && (phase != RESET_WAIT);

	// Registered to line up with the last pixel write
	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn)
			panel_done <= 1'b0;
		else
			panel_done <= line_end && (phase == PANEL);
	end

	// Title is drawn only once
	assert property (@(posedge clock) disable iff (!resetn)
		phase == PANEL |=> phase == PANEL)
		else $error("sequencer left the panel phase");

endmodule

/* hw/glyph_scan.sv */
/*
 * Scan counter over glyph pixels, columns and rows of the current line
 */
`include "text_defs.svh"

module glyph_scan (
	input  logic             clock,
	input  logic             resetn,
	input  text_pkg::phase_t phase,
	output logic [2:0]       px,
	output logic [2:0]       py,
	output logic [3:0]       col,
	output logic [2:0]       row,
	output logic             line_end
);
	import text_pkg::*;

	logic [3:0] col_last;
	logic [2:0] row_last;
	logic       px_last;
	logic       glyph_end;

	// Title is a single line of its own length
	assign col_last = (phase == TITLE) ? 4'(`TEXT_TITLE_LEN - 1) : 4'(`TEXT_REG_COLS - 1);
	assign row_last = (phase == TITLE) ? 3'd0 : 3'(`TEXT_REG_ROWS - 1);

	assign px_last = (px == 3'(`TEXT_GLYPH - 1));
	assign glyph_end = px_last && (py == 3'(`TEXT_GLYPH - 1));
	assign line_end = (phase != RESET_WAIT) && glyph_end && (col == col_last) && (row == row_last);

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			px <= '0;
			py <= '0;
			col <= '0;
			row <= '0;
		end else if (phase == RESET_WAIT || line_end) begin
			px <= '0;    // Back to the origin of the next line
			py <= '0;
			col <= '0;
			row <= '0;
		end else begin
			px <= px + 3'd1;
			if (px_last)
				py <= py + 3'd1;
			if (glyph_end && col == col_last) begin
				col <= '0;
				row <= row + 3'd1;
			end else if (glyph_end) begin
				col <= col + 4'd1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!resetn)
		line_end |=> $past(glyph_end) && col == '0 && row == '0)
		else $error("line end away from a glyph corner");

endmodule

/* hw/pixel_out.sv */
/*
 * Font lookup and pixel write stage
 * Turns the scan position into a registered x, y, color and write strobe
 */
`include "text_defs.svh"

module pixel_out (
	input  logic                  clock,
	input  logic                  resetn,
	input  text_pkg::phase_t      phase,
	input  text_pkg::glyph_code_t code,
	input  logic [2:0]            px,
	input  logic [2:0]            py,
	input  logic [3:0]            col,
	input  logic [2:0]            row,
	output text_pkg::coord_x_t    pix_x,
	output text_pkg::coord_y_t    pix_y,
	output text_pkg::color_t      pix_color,
	output logic                  pix_write
);
	import text_pkg::*;

	glyph_rows_t glyph;
	logic        lit;
	coord_x_t    x_next;
	coord_y_t    y_base;

	assign glyph = FONT[code];
	assign lit = glyph[{py, ~px}];    // Byte py, bit 7 - px

	assign x_next = coord_x_t'(`TEXT_X_BASE) + coord_x_t'(col) * coord_x_t'(`TEXT_CHAR_PITCH)
		+ coord_x_t'(px);

	// Panel rows stack below the title
	assign y_base = (phase == PANEL) ?
		coord_y_t'(`TEXT_REG_Y) + coord_y_t'(row) * coord_y_t'(`TEXT_ROW_PITCH) :
		coord_y_t'(`TEXT_TITLE_Y);

	always_ff @(posedge clock) begin
		pix_x <= x_next;
		pix_y <= y_base + coord_y_t'(py);
		pix_color <= {$bits(color_t){lit}};    // White or black
	end

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn)
			pix_write <= 1'b0;
		else
			pix_write <= (phase == TITLE) || (phase == PANEL);
	end

	assert property (@(posedge clock) disable iff (!resetn)
		pix_write |-> pix_x < `TEXT_SCREEN_W && pix_y < `TEXT_SCREEN_H)
		else $error("pixel write outside the screen");

endmodule

/* hw/text_defs.svh */
/*
 * Register display constants
 * Screen placement, glyph size, line lengths and the APB address map
 */
`ifndef TEXT_DEFS_SVH
`define TEXT_DEFS_SVH

// Text placement on screen
`define TEXT_X_BASE       10
`define TEXT_TITLE_Y      10
`define TEXT_REG_Y        25
`define TEXT_ROW_PITCH    15    // Glyph height plus gap between rows
`define TEXT_CHAR_PITCH   9     // One blank column between glyphs

// Glyph cell
`define TEXT_GLYPH        8

// Line lengths in characters
`define TEXT_TITLE_LEN    16
`define TEXT_REG_COLS     12    // R, digit, colon, space, eight hex digits
`define TEXT_REG_ROWS     8

// Register words sit at byte addresses 0x00 to 0x1C
`define TEXT_APB_LAST     8'h1C

// Visible area
`define TEXT_SCREEN_W     640
`define TEXT_SCREEN_H     480

`endif

/* hw/text_pkg.sv */
/*
 * Register display types, font bitmaps and character codes
 */
package text_pkg;

`include "text_defs.svh"

	typedef logic [9:0] coord_x_t;
	typedef logic [8:0] coord_y_t;
	typedef logic [8:0] color_t;
	typedef logic [5:0] glyph_code_t;

	// Row r in bits [8r+7:8r], leftmost pixel in the MSB of each row
	typedef logic [63:0] glyph_rows_t;

	// One register word, whole or as hex digits
	typedef union packed {
		logic [31:0]      word;
		logic [7:0][3:0]  nib;    // nib[7] is the top digit
	} disp_word_u;

	typedef enum logic [1:0] {
		RESET_WAIT,
		TITLE,
		PANEL
	} phase_t;

	localparam glyph_code_t CODE_R     = 6'd27;
	localparam glyph_code_t CODE_COLON = 6'd36;
	localparam glyph_code_t CODE_SPACE = 6'd37;

	// Rows packed as {row7, ..., row1, row0}
	localparam glyph_rows_t FONT [38] = '{
		64'h7CC2A2928A867C00,    // 0
		64'hFE10101010507000,    // 1
		64'h7C20100804847800,    // 2
		64'hFC02023C0202FC00,    // 3
		64'h080808FE88888800,    // 4
		64'hFC0202FC8080FE00,    // 5
		64'h7C8282FC80807C00,    // 6
		64'h402010080402FE00,    // 7
		64'h7C82827C82827C00,    // 8
		64'h0202027E82827C00,    // 9
		64'h848484FC84847800,    // A
		64'hF88484F88888F000,    // B
		64'h7E80808080807E00,    // C
		64'hF88484848484F800,    // D
		64'hFE8080FC8080FE00,    // E
		64'h808080FC8080FE00,    // F
		64'h7C82828E80827C00,    // G
		64'h848484FC84848400,    // H
		64'h7C10101010107C00,    // I
		64'h7088880808081E00,    // J
		64'h848890E090888400,    // K
		64'hFC80808080808000,    // L
		64'h82828292AAC68200,    // M
		64'h82868A92A2C28200,    // N
		64'h7884848484847800,    // O
		64'h808080F88484F800,    // P
		64'h7488948484847800,    // Q
		64'h848890F88484F800,    // R
		64'h788404047C807C00,    // S
		64'h202020202020FE00,    // T
		64'h7884848484848400,    // U
		64'h0030488484848400,    // V
		64'h0044AAAA92848400,    // W
		64'h0084483030488400,    // X
		64'h2020202030488400,    // Y
		64'hFE4020100804FE00,    // Z
		64'h0060600000606000,    // Colon
		64'h0000000000000000     // Space
	};

	// GENERAL REGISTER
	localparam glyph_code_t TITLE_TEXT [`TEXT_TITLE_LEN] = '{
		6'd16, 6'd14, 6'd23, 6'd14, 6'd27, 6'd10, 6'd21, 6'd37,
		6'd27, 6'd14, 6'd16, 6'd18, 6'd28, 6'd29, 6'd14, 6'd27
	};

endpackage

/* hw/text_top.sv */
/*
 * Register display top level
 * APB register bank feeding an 8x8 text renderer that emits pixel writes
 */
`include "text_defs.svh"

module text_top (
	input  logic                 clock,
	input  logic                 resetn,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [7:0]           paddr,
	input  text_pkg::disp_word_u pwdata,
	output text_pkg::disp_word_u prdata,
	output logic                 pready,
	output logic                 pslverr,
	output text_pkg::coord_x_t   pix_x,
	output text_pkg::coord_y_t   pix_y,
	output text_pkg::color_t     pix_color,
	output logic                 pix_write,
	output logic                 panel_done
);
	import text_pkg::*;

	disp_word_u  shown [`TEXT_REG_ROWS];
	phase_t      phase;
	logic        panel_start;
	logic        line_end;
	logic [2:0]  px;
	logic [2:0]  py;
	logic [3:0]  col;
	logic [2:0]  row;
	glyph_code_t code;

	apb_regs regs_i (
		.clock      (clock),
		.resetn     (resetn),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.panel_start(panel_start),
		.shown      (shown)
	);

	draw_sequencer seq_i (
		.clock      (clock),
		.resetn     (resetn),
		.line_end   (line_end),
		.phase      (phase),
		.panel_start(panel_start),
		.panel_done (panel_done)
	);

	glyph_scan scan_i (
		.clock   (clock),
		.resetn  (resetn),
		.phase   (phase),
		.px      (px),
		.py      (py),
		.col     (col),
		.row     (row),
		.line_end(line_end)
	);

	char_select sel_i (
		.phase(phase),
		.col  (col),
		.row  (row),
		.shown(shown),
		.code (code)
	);

	pixel_out pix_i (
		.clock    (clock),
		.resetn   (resetn),
		.phase    (phase),
		.code     (code),
		.px       (px),
		.py       (py),
		.col      (col),
		.row      (row),
		.pix_x    (pix_x),
		.pix_y    (pix_y),
		.pix_color(pix_color),
		.pix_write(pix_write)
	);

endmodule

/* list.f */
+incdir+hw
hw/text_pkg.sv
hw/apb_regs.sv
hw/draw_sequencer.sv
hw/glyph_scan.sv
hw/char_select.sv
hw/pixel_out.sv
hw/text_top.sv
bench/tb_text.sv

/* run.sh */
#!/bin/sh
# Build and run the register display testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_text -Mdir obj_dir \
	> "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_text > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$SIM_LOG"; then
	exit 1
fi
exit 0
